//--- rtl/exe_pkg.sv
// --------------------------------------------------------------------------
// RV64I base encodings only; no loads, stores, M or A extension
// immediate ALU forms keep their own op so the ALU table mirrors the ISA
// --------------------------------------------------------------------------
`default_nettype none

package exe_pkg;

  // data path width
  localparam int XLEN = 64;

  // r-type view, also used for funct7 and rs2 of shift immediates
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } exe_inst_r_t;

  // i-type view, imm doubles as CSR address
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } exe_inst_i_t;

  typedef union packed {
    exe_inst_r_t r;
    exe_inst_i_t i;
  } exe_inst_u;

  // major opcodes
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

  // internal operation, OP_NONE marks an illegal encoding
  typedef enum logic [5:0] {
    OP_NONE,
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
    OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
    OP_SLLI, OP_SRLI, OP_SRAI, OP_SLTI, OP_SLTIU,
    OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
    OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI
  } exe_op_e;

endpackage

`default_nettype wire

//--- rtl/csr_pkg.sv
// --------------------------------------------------------------------------
// machine-mode CSRs only; no privilege checks on any address
// --------------------------------------------------------------------------
`default_nettype none

package csr_pkg;

  // 12-bit CSR address space
  typedef logic [11:0] csr_addr_t;

  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  // read-only counters in this core
  localparam csr_addr_t CSR_MCYCLE   = 12'hB00;
  localparam csr_addr_t CSR_MINSTRET = 12'hB02;

  // CSR operation kind, equal to funct3[1:0] of the SYSTEM opcode
  // funct3[2] selects the zimm form
  typedef enum logic [1:0] {
    CSR_RW = 2'b01,
    CSR_RS = 2'b10,
    CSR_RC = 2'b11
  } csr_op_e;

endpackage

`default_nettype wire

//--- rtl/exe_decode.sv
// --------------------------------------------------------------------------
// combinational; ECALL, EBREAK and other SYSTEM funct3=0 words are illegal
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module exe_decode
  import exe_pkg::*;
  import csr_pkg::*;
(
  input  exe_inst_u       i_inst,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_rs1_data,
  input  logic [XLEN-1:0] i_rs2_data,
  output exe_op_e         o_op,
  output logic [XLEN-1:0] o_op1,
  output logic [XLEN-1:0] o_op2,
  output logic [XLEN-1:0] o_op3,
  output logic [4:0]      o_rd_addr,
  output logic            o_rd_wen,
  output csr_addr_t       o_csr_addr,
  output logic            o_illegal
);

  logic [31:0]     word;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            f7_zero;
  logic            f7_alt;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] zimm;

  // raw bits for the scattered immediates
  assign word   = i_inst;
  assign opcode = i_inst.r.opcode;
  assign funct3 = i_inst.i.funct3;
  assign funct7 = i_inst.r.funct7;
  // funct7 0100000 picks SUB and SRA variants
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  assign imm_i = {{(XLEN-12){i_inst.i.imm[11]}}, i_inst.i.imm};
  assign imm_b = {{(XLEN-12){word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){word[31]}}, word[31:12], 12'h000};
  assign imm_j = {{(XLEN-20){word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
  // CSR immediate sits in the rs1 field
  assign zimm  = {{(XLEN-5){1'b0}}, i_inst.i.rs1};

  // operation select
  always_comb begin
    o_op = OP_NONE;
    case (opcode)
      OPC_LUI:   o_op = OP_LUI;
      OPC_AUIPC: o_op = OP_AUIPC;
      OPC_JAL:   o_op = OP_JAL;
      OPC_JALR: begin
        if (funct3 == 3'b000) o_op = OP_JALR;
      end
      OPC_BRANCH: begin
        case (funct3)
          3'b000:  o_op = OP_BEQ;
          3'b001:  o_op = OP_BNE;
          3'b100:  o_op = OP_BLT;
          3'b101:  o_op = OP_BGE;
          3'b110:  o_op = OP_BLTU;
          3'b111:  o_op = OP_BGEU;
          default: o_op = OP_NONE;
        endcase
      end
      OPC_OP_IMM: begin
        case (funct3)
          3'b000: o_op = OP_ADDI;
          3'b010: o_op = OP_SLTI;
          3'b011: o_op = OP_SLTIU;
          3'b100: o_op = OP_XORI;
          3'b110: o_op = OP_ORI;
          3'b111: o_op = OP_ANDI;
          // 6-bit shamt, imm[11:6] holds the shift kind
          3'b001: begin
            if (funct7[6:1] == 6'b000000) o_op = OP_SLLI;
          end
          default: begin
            if (funct7[6:1] == 6'b000000) o_op = OP_SRLI;
            else if (funct7[6:1] == 6'b010000) o_op = OP_SRAI;
          end
        endcase
      end
      OPC_OP: begin
        if (f7_zero) begin
          case (funct3)
            3'b000:  o_op = OP_ADD;
            3'b001:  o_op = OP_SLL;
            3'b010:  o_op = OP_SLT;
            3'b011:  o_op = OP_SLTU;
            3'b100:  o_op = OP_XOR;
            3'b101:  o_op = OP_SRL;
            3'b110:  o_op = OP_OR;
            default: o_op = OP_AND;
          endcase
        end else if (f7_alt && funct3 == 3'b000) begin
          o_op = OP_SUB;
        end else if (f7_alt && funct3 == 3'b101) begin
          o_op = OP_SRA;
        end
      end
      OPC_OP_IMM_32: begin
        if (funct3 == 3'b000) o_op = OP_ADDIW;
        else if (funct3 == 3'b001 && f7_zero) o_op = OP_SLLIW;
        else if (funct3 == 3'b101 && f7_zero) o_op = OP_SRLIW;
        else if (funct3 == 3'b101 && f7_alt) o_op = OP_SRAIW;
      end
      OPC_OP_32: begin
        if (funct3 == 3'b000 && f7_zero) o_op = OP_ADDW;
        else if (funct3 == 3'b000 && f7_alt) o_op = OP_SUBW;
        else if (funct3 == 3'b001 && f7_zero) o_op = OP_SLLW;
        else if (funct3 == 3'b101 && f7_zero) o_op = OP_SRLW;
        else if (funct3 == 3'b101 && f7_alt) o_op = OP_SRAW;
      end
      OPC_SYSTEM: begin
        case (funct3[1:0])
          CSR_RW:  o_op = funct3[2] ? OP_CSRRWI : OP_CSRRW;
          CSR_RS:  o_op = funct3[2] ? OP_CSRRSI : OP_CSRRS;
          CSR_RC:  o_op = funct3[2] ? OP_CSRRCI : OP_CSRRC;
          default: o_op = OP_NONE;
        endcase
      end
      default: o_op = OP_NONE;
    endcase
  end

  // operand build
  always_comb begin
    o_op1 = i_rs1_data;
    o_op2 = i_rs2_data;
    // branch target by default
    o_op3 = i_pc + imm_b;
    case (opcode)
      OPC_LUI: o_op1 = imm_u;
      OPC_AUIPC: begin
        o_op1 = imm_u;
        o_op2 = i_pc;
      end
      OPC_JAL: begin
        o_op2 = i_pc;
        o_op3 = i_pc + imm_j;
      end
      // op3 carries the link value
      OPC_JALR: begin
        o_op2 = imm_i;
        o_op3 = i_pc + XLEN'(4);
      end
      OPC_OP_IMM, OPC_OP_IMM_32: o_op2 = imm_i;
      OPC_SYSTEM: begin
        if (funct3[2]) o_op1 = zimm;
      end
      default: o_op1 = i_rs1_data;
    endcase
  end

  assign o_rd_addr  = i_inst.r.rd;
  assign o_csr_addr = i_inst.i.imm;
  assign o_illegal  = (o_op == OP_NONE);
  // no write for branches, x0 or illegal words
  assign o_rd_wen   = !o_illegal && (opcode != OPC_BRANCH) && (o_rd_addr != 5'd0);

endmodule

`default_nettype wire

//--- rtl/exe_alu.sv
// --------------------------------------------------------------------------
// combinational; i_csr_rdata must be the CSR value before this write
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module exe_alu
  import exe_pkg::*;
(
  input  exe_op_e         i_op,
  input  logic [XLEN-1:0] i_op1,
  input  logic [XLEN-1:0] i_op2,
  input  logic [XLEN-1:0] i_op3,
  input  logic [XLEN-1:0] i_csr_rdata,
  output logic [XLEN-1:0] o_rd_data,
  output logic            o_pc_jmp,
  output logic [XLEN-1:0] o_pc_jmpaddr,
  output logic            o_is_csr,
  output logic [XLEN-1:0] o_csr_wdata
);

  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] diff;
  logic            lt;
  logic            ltu;
  logic [31:0]     sllw;
  logic [31:0]     srlw;
  logic [31:0]     sraw;

  // word results go back out sign-extended
  function automatic logic [XLEN-1:0] sext32(input logic [31:0] v);
    return {{(XLEN-32){v[31]}}, v};
  endfunction

  assign sum  = i_op1 + i_op2;
  assign diff = i_op1 - i_op2;
  assign lt   = $signed(i_op1) < $signed(i_op2);
  assign ltu  = i_op1 < i_op2;
  // W shifts use a 5-bit shamt on the low word
  assign sllw = i_op1[31:0] << i_op2[4:0];
  assign srlw = i_op1[31:0] >> i_op2[4:0];
  assign sraw = $signed(i_op1[31:0]) >>> i_op2[4:0];

  // rd result
  always_comb begin
    o_rd_data = '0;
    case (i_op)
      OP_ADD, OP_ADDI:   o_rd_data = sum;
      OP_SUB:            o_rd_data = diff;
      OP_AND, OP_ANDI:   o_rd_data = i_op1 & i_op2;
      OP_OR, OP_ORI:     o_rd_data = i_op1 | i_op2;
      OP_XOR, OP_XORI:   o_rd_data = i_op1 ^ i_op2;
      OP_SLL, OP_SLLI:   o_rd_data = i_op1 << i_op2[5:0];
      OP_SRL, OP_SRLI:   o_rd_data = i_op1 >> i_op2[5:0];
      OP_SRA, OP_SRAI:   o_rd_data = $signed(i_op1) >>> i_op2[5:0];
      OP_SLT, OP_SLTI:   o_rd_data = XLEN'(lt);
      OP_SLTU, OP_SLTIU: o_rd_data = XLEN'(ltu);
      OP_ADDW, OP_ADDIW: o_rd_data = sext32(sum[31:0]);
      OP_SUBW:           o_rd_data = sext32(diff[31:0]);
      OP_SLLW, OP_SLLIW: o_rd_data = sext32(sllw);
      OP_SRLW, OP_SRLIW: o_rd_data = sext32(srlw);
      OP_SRAW, OP_SRAIW: o_rd_data = sext32(sraw);
      OP_LUI:            o_rd_data = i_op1;
      OP_AUIPC:          o_rd_data = sum;
      // op2 holds pc for JAL
      OP_JAL:            o_rd_data = i_op2 + XLEN'(4);
      OP_JALR:           o_rd_data = i_op3;
      OP_CSRRW, OP_CSRRS, OP_CSRRC,
      OP_CSRRWI, OP_CSRRSI, OP_CSRRCI: o_rd_data = i_csr_rdata;
      default:           o_rd_data = '0;
    endcase
  end

  // branch and jump decision
  always_comb begin
    o_pc_jmp     = 1'b0;
    o_pc_jmpaddr = i_op3;
    case (i_op)
      OP_BEQ:  o_pc_jmp = (i_op1 == i_op2);
      OP_BNE:  o_pc_jmp = (i_op1 != i_op2);
      OP_BLT:  o_pc_jmp = lt;
      OP_BGE:  o_pc_jmp = !lt;
      OP_BLTU: o_pc_jmp = ltu;
      OP_BGEU: o_pc_jmp = !ltu;
      OP_JAL:  o_pc_jmp = 1'b1;
      OP_JALR: begin
        o_pc_jmp     = 1'b1;
        o_pc_jmpaddr = {sum[XLEN-1:1], 1'b0};
      end
      // target reads zero outside control flow
      default: o_pc_jmpaddr = '0;
    endcase
  end

  // CSR write value, op1 is rs1 or zimm
  always_comb begin
    o_is_csr    = 1'b1;
    o_csr_wdata = '0;
    case (i_op)
      OP_CSRRW, OP_CSRRWI: o_csr_wdata = i_op1;
      OP_CSRRS, OP_CSRRSI: o_csr_wdata = i_csr_rdata | i_op1;
      OP_CSRRC, OP_CSRRCI: o_csr_wdata = i_csr_rdata & ~i_op1;
      default:             o_is_csr = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/exe_cycle_counter.sv
// --------------------------------------------------------------------------
// CNT_W up to XLEN; both counters wrap silently at CNT_W bits
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module exe_cycle_counter #(
  parameter int CNT_W = 64
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_retire,
  output logic [CNT_W-1:0] o_mcycle,
  output logic [CNT_W-1:0] o_minstret
);

  // mcycle runs free from the first cycle out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      o_mcycle <= '0;
    end else begin
      o_mcycle <= o_mcycle + 1'b1;
    end
  end

  // one count per retire pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      o_minstret <= '0;
    end else if (i_retire) begin
      o_minstret <= o_minstret + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/exe_csr_file.sv
// --------------------------------------------------------------------------
// unknown addresses read 0; counter and unknown writes are dropped
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module exe_csr_file
  import exe_pkg::*;
  import csr_pkg::*;
#(
  parameter int CNT_W = 64
) (
  input  logic            clk,
  input  logic            rst,
  input  csr_addr_t       i_addr,
  input  logic            i_wen,
  input  logic [XLEN-1:0] i_wdata,
  input  logic            i_retire,
  output logic [XLEN-1:0] o_rdata
);

  logic [XLEN-1:0]  mscratch;
  logic [XLEN-1:0]  mtvec;
  logic [CNT_W-1:0] mcycle;
  logic [CNT_W-1:0] minstret;

  exe_cycle_counter #(
    .CNT_W(CNT_W)
  ) u_counter (
    .clk       (clk),
    .rst       (rst),
    .i_retire  (i_retire),
    .o_mcycle  (mcycle),
    .o_minstret(minstret)
  );

  // writable machine registers
  always_ff @(posedge clk) begin
    if (rst) begin
      mscratch <= '0;
      mtvec    <= '0;
    end else if (i_wen) begin
      if (i_addr == CSR_MSCRATCH) begin
        mscratch <= i_wdata;
      end
      // direct mode only, base kept word aligned
      if (i_addr == CSR_MTVEC) begin
        mtvec <= {i_wdata[XLEN-1:2], 2'b00};
      end
    end
  end

  // read mux, counters zero-extended to XLEN
  always_comb begin
    case (i_addr)
      CSR_MSCRATCH: o_rdata = mscratch;
      CSR_MTVEC:    o_rdata = mtvec;
      CSR_MCYCLE:   o_rdata = XLEN'(mcycle);
      CSR_MINSTRET: o_rdata = XLEN'(minstret);
      default:      o_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/exe_ctrl.sv
// --------------------------------------------------------------------------
// i_valid is sampled in IDLE only; the source must wait for o_done
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module exe_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic i_valid,
  input  logic i_is_csr,
  output logic o_capture,
  output logic o_busy,
  output logic o_csr_wen,
  output logic o_result_load,
  output logic o_done
);

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    CSR_WB,
    DONE
  } state_e;

  state_e state_q;
  state_e state_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d       = state_q;
    o_capture     = 1'b0;
    o_csr_wen     = 1'b0;
    o_result_load = 1'b0;
    o_done        = 1'b0;
    case (state_q)
      IDLE: begin
        if (i_valid) begin
          o_capture = 1'b1;
          state_d   = EXEC;
        end
      end
      // i_is_csr comes from the captured op
      EXEC: begin
        if (i_is_csr) begin
          state_d = CSR_WB;
        end else begin
          o_result_load = 1'b1;
          state_d       = DONE;
        end
      end
      // CSR write and old-value capture share this edge
      CSR_WB: begin
        o_csr_wen     = 1'b1;
        o_result_load = 1'b1;
        state_d       = DONE;
      end
      // o_done also retires the instruction
      default: begin
        o_done  = 1'b1;
        state_d = IDLE;
      end
    endcase
  end

  // busy through the o_done cycle
  assign o_busy = (state_q != IDLE);

endmodule

`default_nettype wire

//--- rtl/exe_top.sv
// --------------------------------------------------------------------------
// o_done 2 cycles after i_valid, 3 for CSR ops; results hold until next
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module exe_top
  import exe_pkg::*;
  import csr_pkg::*;
#(
  parameter int CNT_W = 64
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            i_valid,
  input  exe_inst_u       i_inst,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_rs1_data,
  input  logic [XLEN-1:0] i_rs2_data,
  output logic            o_busy,
  output logic            o_done,
  output logic            o_rd_wen,
  output logic [4:0]      o_rd_addr,
  output logic [XLEN-1:0] o_rd_data,
  output logic            o_pc_jmp,
  output logic [XLEN-1:0] o_pc_jmpaddr,
  output logic            o_illegal
);

  // decoder outputs
  exe_op_e         dec_op;
  logic [XLEN-1:0] dec_op1;
  logic [XLEN-1:0] dec_op2;
  logic [XLEN-1:0] dec_op3;
  logic [4:0]      dec_rd_addr;
  logic            dec_rd_wen;
  csr_addr_t       dec_csr_addr;
  logic            dec_illegal;
  // captured fields
  exe_op_e         op_q;
  logic [XLEN-1:0] op1_q;
  logic [XLEN-1:0] op2_q;
  logic [XLEN-1:0] op3_q;
  logic [4:0]      rd_addr_q;
  logic            rd_wen_q;
  csr_addr_t       csr_addr_q;
  logic            illegal_q;
  // ALU and CSR
  logic [XLEN-1:0] alu_rd_data;
  logic            alu_pc_jmp;
  logic [XLEN-1:0] alu_pc_jmpaddr;
  logic            alu_is_csr;
  logic [XLEN-1:0] alu_csr_wdata;
  logic [XLEN-1:0] csr_rdata;
  // control strobes
  logic            capture;
  logic            csr_wen;
  logic            result_load;

  exe_decode u_decode (
    .i_inst    (i_inst),
    .i_pc      (i_pc),
    .i_rs1_data(i_rs1_data),
    .i_rs2_data(i_rs2_data),
    .o_op      (dec_op),
    .o_op1     (dec_op1),
    .o_op2     (dec_op2),
    .o_op3     (dec_op3),
    .o_rd_addr (dec_rd_addr),
    .o_rd_wen  (dec_rd_wen),
    .o_csr_addr(dec_csr_addr),
    .o_illegal (dec_illegal)
  );

  // decoded fields, loaded once per accepted i_valid
  always_ff @(posedge clk) begin
    if (capture) begin
      op_q       <= dec_op;
      op1_q      <= dec_op1;
      op2_q      <= dec_op2;
      op3_q      <= dec_op3;
      rd_addr_q  <= dec_rd_addr;
      rd_wen_q   <= dec_rd_wen;
      csr_addr_q <= dec_csr_addr;
      illegal_q  <= dec_illegal;
    end
  end

  exe_alu u_alu (
    .i_op        (op_q),
    .i_op1       (op1_q),
    .i_op2       (op2_q),
    .i_op3       (op3_q),
    .i_csr_rdata (csr_rdata),
    .o_rd_data   (alu_rd_data),
    .o_pc_jmp    (alu_pc_jmp),
    .o_pc_jmpaddr(alu_pc_jmpaddr),
    .o_is_csr    (alu_is_csr),
    .o_csr_wdata (alu_csr_wdata)
  );

  exe_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .i_valid      (i_valid),
    .i_is_csr     (alu_is_csr),
    .o_capture    (capture),
    .o_busy       (o_busy),
    .o_csr_wen    (csr_wen),
    .o_result_load(result_load),
    .o_done       (o_done)
  );

  exe_csr_file #(
    .CNT_W(CNT_W)
  ) u_csr (
    .clk     (clk),
    .rst     (rst),
    .i_addr  (csr_addr_q),
    .i_wen   (csr_wen),
    .i_wdata (alu_csr_wdata),
    .i_retire(o_done),
    .o_rdata (csr_rdata)
  );

  // result flags; in CSR_WB rd data samples the old CSR value
  // on the same edge that writes the new one
  always_ff @(posedge clk) begin
    if (rst) begin
      o_rd_wen  <= 1'b0;
      o_pc_jmp  <= 1'b0;
      o_illegal <= 1'b0;
    end else if (result_load) begin
      o_rd_wen  <= rd_wen_q;
      o_pc_jmp  <= alu_pc_jmp;
      o_illegal <= illegal_q;
    end
  end

  // result payload
  always_ff @(posedge clk) begin
    if (result_load) begin
      o_rd_addr    <= rd_addr_q;
      o_rd_data    <= alu_rd_data;
      o_pc_jmpaddr <= alu_pc_jmpaddr;
    end
  end

endmodule

`default_nettype wire

//--- dv/exe_tb_table.svh
// --------------------------------------------------------------------------
// columns are kind, inst, pc, rs1, rs2, exp rd, wen, jmp, jmpaddr, illegal
// K_RND rows draw rs1/rs2 at run time, K_CNT rows expect the retire count
// --------------------------------------------------------------------------

localparam int NUM_ROWS = 60;

localparam row_t ROWS [NUM_ROWS] = '{
  // register and immediate ALU forms, rd x3
  '{K_FIX, 'h002081b3, 'h0, 'h5, 'h7, 'hc, 1, 0, 'h0, 0},
  '{K_FIX, 'h402081b3, 'h0, 'h3, 'h5, 'hfffffffffffffffe, 1, 0, 'h0, 0},
  '{K_FIX, 'h0020a1b3, 'h0, 'hffffffffffffffff, 'h1, 'h1, 1, 0, 'h0, 0},
  '{K_FIX, 'h0020b1b3, 'h0, 'hffffffffffffffff, 'h1, 'h0, 1, 0, 'h0, 0},
  '{K_FIX, 'h0020d1b3, 'h0, 'h8000000000000000, 'h4, 'h0800000000000000, 1, 0, 'h0, 0},
  '{K_FIX, 'h4020d1b3, 'h0, 'h8000000000000000, 'h4, 'hf800000000000000, 1, 0, 'h0, 0},
  // shamt masked to 6 bits
  '{K_FIX, 'h002091b3, 'h0, 'h1, 'h43, 'h8, 1, 0, 'h0, 0},
  '{K_FIX, 'h002081bb, 'h0, 'h7fffffff, 'h1, 'hffffffff80000000, 1, 0, 'h0, 0},
  '{K_FIX, 'h402081bb, 'h0, 'h0, 'h1, 'hffffffffffffffff, 1, 0, 'h0, 0},
  '{K_FIX, 'h4020d1bb, 'h0, 'h80000000, 'h24, 'hfffffffff8000000, 1, 0, 'h0, 0},
  '{K_FIX, 'h0020d1bb, 'h0, 'hffffffff80000000, 'h4, 'h8000000, 1, 0, 'h0, 0},
  '{K_FIX, 'hfff08193, 'h0, 'h10, 'h0, 'hf, 1, 0, 'h0, 0},
  '{K_FIX, 'hfff0b193, 'h0, 'h5, 'h0, 'h1, 1, 0, 'h0, 0},
  '{K_FIX, 'h43f0d193, 'h0, 'h8000000000000000, 'h0, 'hffffffffffffffff, 1, 0, 'h0, 0},
  '{K_FIX, 'h0010819b, 'h0, 'h7fffffff, 'h0, 'hffffffff80000000, 1, 0, 'h0, 0},
  '{K_FIX, 'h800001b7, 'h0, 'h0, 'h0, 'hffffffff80000000, 1, 0, 'h0, 0},
  '{K_FIX, 'h00001197, 'h1000, 'h0, 'h0, 'h2000, 1, 0, 'h0, 0},
  // rd x0, no write
  '{K_FIX, 'h00208033, 'h0, 'h5, 'h7, 'hc, 0, 0, 'h0, 0},
  // branches, each kind taken then not taken
  '{K_FIX, 'h00208863, 'h100, 'h1234, 'h1234, 'h0, 0, 1, 'h110, 0},
  '{K_FIX, 'h00208863, 'h100, 'h1, 'h2, 'h0, 0, 0, 'h110, 0},
  '{K_FIX, 'hfe209ce3, 'h200, 'h1, 'h2, 'h0, 0, 1, 'h1f8, 0},
  '{K_FIX, 'hfe209ce3, 'h200, 'h3, 'h3, 'h0, 0, 0, 'h1f8, 0},
  '{K_FIX, 'h0020c863, 'h100, 'hffffffffffffffff, 'h1, 'h0, 0, 1, 'h110, 0},
  '{K_FIX, 'h0020c863, 'h100, 'h1, 'hffffffffffffffff, 'h0, 0, 0, 'h110, 0},
  '{K_FIX, 'h0020d863, 'h100, 'h1, 'hffffffffffffffff, 'h0, 0, 1, 'h110, 0},
  '{K_FIX, 'h0020d863, 'h100, 'hffffffffffffffff, 'h1, 'h0, 0, 0, 'h110, 0},
  '{K_FIX, 'h0020e863, 'h100, 'h1, 'hffffffffffffffff, 'h0, 0, 1, 'h110, 0},
  '{K_FIX, 'h0020e863, 'h100, 'hffffffffffffffff, 'h1, 'h0, 0, 0, 'h110, 0},
  '{K_FIX, 'h0020f863, 'h100, 'hffffffffffffffff, 'h1, 'h0, 0, 1, 'h110, 0},
  '{K_FIX, 'h0020f863, 'h100, 'h1, 'hffffffffffffffff, 'h0, 0, 0, 'h110, 0},
  // jal x1 +0x20, jalr x1 3(x5) with bit 0 cleared
  '{K_FIX, 'h020000ef, 'h400, 'h0, 'h0, 'h404, 1, 1, 'h420, 0},
  '{K_FIX, 'h003280e7, 'h500, 'h1000, 'h0, 'h504, 1, 1, 'h1002, 0},
  // illegal words
  '{K_FIX, 'h00000000, 'h0, 'h0, 'h0, 'h0, 0, 0, 'h0, 1},
  '{K_FIX, 'hffffffff, 'h0, 'h0, 'h0, 'h0, 0, 0, 'h0, 1},
  // mscratch rw, rs, rc, then rsi as a plain read
  '{K_FIX, 'h340091f3, 'h0, 'hdeadbeef00001111, 'h0, 'h0, 1, 0, 'h0, 0},
  '{K_FIX, 'h3400a1f3, 'h0, 'hff, 'h0, 'hdeadbeef00001111, 1, 0, 'h0, 0},
  '{K_FIX, 'h3400b1f3, 'h0, 'h1100, 'h0, 'hdeadbeef000011ff, 1, 0, 'h0, 0},
  '{K_FIX, 'h340061f3, 'h0, 'h0, 'h0, 'hdeadbeef000000ff, 1, 0, 'h0, 0},
  // mtvec drops the low two bits
  '{K_FIX, 'h305fd1f3, 'h0, 'h0, 'h0, 'h0, 1, 0, 'h0, 0},
  '{K_FIX, 'h3050a1f3, 'h0, 'h0, 'h0, 'h1c, 1, 0, 'h0, 0},
  // unknown address 0x7c0
  '{K_FIX, 'h7c0091f3, 'h0, 'h55, 'h0, 'h0, 1, 0, 'h0, 0},
  '{K_FIX, 'h7c00a1f3, 'h0, 'h0, 'h0, 'h0, 1, 0, 'h0, 0},
  // minstret read, write attempt, read again
  '{K_CNT, 'hb020a1f3, 'h0, 'h0, 'h0, 'h0, 1, 0, 'h0, 0},
  '{K_CNT, 'hb02091f3, 'h0, 'h1234, 'h0, 'h0, 1, 0, 'h0, 0},
  '{K_CNT, 'hb020a1f3, 'h0, 'h0, 'h0, 'h0, 1, 0, 'h0, 0},
  // random operands, OP then OP-32
  '{K_RND, 'h002081b3, 'h0, 'h0, 'h0, 'h0, 1, 0, 'h0, 0},
  '{K_RND, 'h402081b3, 'h0, 'h0, 'h0, 'h0, 1, 0, 'h0, 0},
  '{K_RND, 'h002091b3, 'h0, 'h0, 'h0, 'h0, 1, 0, 'h0, 0},
  '{K_RND, 'h0020a1b3, 'h0, 'h0, 'h0, 'h0, 1, 0, 'h0, 0},
  '{K_RND, 'h0020b1b3, 'h0, 'h0, 'h0, 'h0, 1, 0, 'h0, 0},
  '{K_RND, 'h0020c1b3, 'h0, 'h0, 'h0, 'h0, 1, 0, 'h0, 0},
  '{K_RND, 'h0020d1b3, 'h0, 'h0, 'h0, 'h0, 1, 0, 'h0, 0},
  '{K_RND, 'h4020d1b3, 'h0, 'h0, 'h0, 'h0, 1, 0, 'h0, 0},
  '{K_RND, 'h0020e1b3, 'h0, 'h0, 'h0, 'h0, 1, 0, 'h0, 0},
  '{K_RND, 'h0020f1b3, 'h0, 'h0, 'h0, 'h0, 1, 0, 'h0, 0},
  '{K_RND, 'h002081bb, 'h0, 'h0, 'h0, 'h0, 1, 0, 'h0, 0},
  '{K_RND, 'h402081bb, 'h0, 'h0, 'h0, 'h0, 1, 0, 'h0, 0},
  '{K_RND, 'h002091bb, 'h0, 'h0, 'h0, 'h0, 1, 0, 'h0, 0},
  '{K_RND, 'h0020d1bb, 'h0, 'h0, 'h0, 'h0, 1, 0, 'h0, 0},
  '{K_RND, 'h4020d1bb, 'h0, 'h0, 'h0, 'h0, 1, 0, 'h0, 0}
};

//--- dv/exe_tb.sv
// --------------------------------------------------------------------------
// drives exe_top from the row table; stops at the first mismatch
// random rows are R-type only, expected values from the RV64I rules
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module exe_tb
  import exe_pkg::*;
();

  localparam int          RST_CYCLES = 8;
  localparam logic [31:0] SEED       = 32'h1a5e_6543;

  // row kinds: fixed operands, random operands, minstret read
  localparam logic [1:0] K_FIX = 2'd0;
  localparam logic [1:0] K_RND = 2'd1;
  localparam logic [1:0] K_CNT = 2'd2;

  typedef struct packed {
    logic [1:0]      kind;
    logic [31:0]     inst;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] exp_rd;
    logic            exp_wen;
    logic            exp_jmp;
    logic [XLEN-1:0] exp_jmpaddr;
    logic            exp_illegal;
  } row_t;

  `include "exe_tb_table.svh"

  // 4 cycles covers the slowest row plus the idle step
  localparam int MAX_CYCLES = NUM_ROWS * 4 + RST_CYCLES + 20;

  logic            clk;
  logic            rst;
  logic            i_valid;
  exe_inst_u       i_inst;
  logic [XLEN-1:0] i_pc;
  logic [XLEN-1:0] i_rs1_data;
  logic [XLEN-1:0] i_rs2_data;
  logic            o_busy;
  logic            o_done;
  logic            o_rd_wen;
  logic [4:0]      o_rd_addr;
  logic [XLEN-1:0] o_rd_data;
  logic            o_pc_jmp;
  logic [XLEN-1:0] o_pc_jmpaddr;
  logic            o_illegal;

  int              cycle_count;
  // o_done pulses seen since reset, equals minstret
  int              retired;
  int unsigned     first_draw;

  exe_top #(
    .CNT_W(64)
  ) i_dut (
    .clk         (clk),
    .rst         (rst),
    .i_valid     (i_valid),
    .i_inst      (i_inst),
    .i_pc        (i_pc),
    .i_rs1_data  (i_rs1_data),
    .i_rs2_data  (i_rs2_data),
    .o_busy      (o_busy),
    .o_done      (o_done),
    .o_rd_wen    (o_rd_wen),
    .o_rd_addr   (o_rd_addr),
    .o_rd_data   (o_rd_data),
    .o_pc_jmp    (o_pc_jmp),
    .o_pc_jmpaddr(o_pc_jmpaddr),
    .o_illegal   (o_illegal)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_error();
    $display("Errors found");
    $fatal(1, "simulation stopped at first error");
  endtask

  // run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      stop_on_error();
    end
  end

  task automatic check_data(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Fail t=%0t %s got=%h exp=%h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail t=%0t %s got=%b exp=%b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_addr(input string name, input logic [4:0] got,
                            input logic [4:0] exp);
    if (got !== exp) begin
      $display("Fail t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Fail t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // RV64I R-type result for OP and OP-32
  function automatic logic [XLEN-1:0] ref_rtype(input logic [31:0] inst,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic [2:0]      f3;
    logic            alt;
    logic [31:0]     w;
    logic [XLEN-1:0] r;
    f3  = inst[14:12];
    alt = inst[30];
    w   = '0;
    r   = '0;
    // opcode bit 3 marks OP-32
    if (!inst[3]) begin
      case (f3)
        3'd0: r = alt ? a - b : a + b;
        3'd1: r = a << b[5:0];
        3'd2: r = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
        3'd3: r = {{(XLEN-1){1'b0}}, a < b};
        3'd4: r = a ^ b;
        3'd5: begin
          if (alt) r = $signed(a) >>> b[5:0];
          else r = a >> b[5:0];
        end
        3'd6: r = a | b;
        default: r = a & b;
      endcase
    end else begin
      case (f3)
        3'd0: w = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
        3'd1: w = a[31:0] << b[4:0];
        default: begin
          if (alt) w = $signed(a[31:0]) >>> b[4:0];
          else w = a[31:0] >> b[4:0];
        end
      endcase
      // word result sign-extended
      r = {{(XLEN-32){w[31]}}, w};
    end
    return r;
  endfunction

  // one instruction, 1 ns past the edge, DUT must be idle
  task automatic issue(input logic [31:0] inst, input logic [XLEN-1:0] pc,
                       input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] rs2);
    check_bit("o_busy", o_busy, 1'b0);
    i_inst     = inst;
    i_pc       = pc;
    i_rs1_data = rs1;
    i_rs2_data = rs2;
    i_valid    = 1'b1;
    @(posedge clk);
    #1;
    i_valid = 1'b0;
  endtask

  // cycles from i_valid to o_done
  task automatic wait_done(output int lat);
    lat = 1;
    while (!o_done) begin
      @(posedge clk);
      #1;
      lat++;
    end
    retired++;
  endtask

  task automatic run_row(input row_t r);
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] exp_rd;
    logic [6:0]      opc;
    int              exp_lat;
    int              lat;
    rs1    = r.rs1;
    rs2    = r.rs2;
    exp_rd = r.exp_rd;
    opc    = r.inst[6:0];
    if (r.kind == K_RND) begin
      rs1    = {$urandom, $urandom};
      rs2    = {$urandom, $urandom};
      exp_rd = ref_rtype(r.inst, rs1, rs2);
    end else if (r.kind == K_CNT) begin
      exp_rd = XLEN'(retired);
    end
    // CSR access takes the extra writeback cycle
    exp_lat = (opc == OPC_SYSTEM && r.inst[13:12] != 2'b00) ? 3 : 2;
    issue(r.inst, r.pc, rs1, rs2);
    wait_done(lat);
    check_count("o_done latency", lat, exp_lat);
    check_bit("o_illegal", o_illegal, r.exp_illegal);
    check_bit("o_rd_wen", o_rd_wen, r.exp_wen);
    check_bit("o_pc_jmp", o_pc_jmp, r.exp_jmp);
    if (r.exp_wen) begin
      check_addr("o_rd_addr", o_rd_addr, r.inst[11:7]);
      check_data("o_rd_data", o_rd_data, exp_rd);
    end
    if (opc == OPC_BRANCH || opc == OPC_JAL || opc == OPC_JALR) begin
      check_data("o_pc_jmpaddr", o_pc_jmpaddr, r.exp_jmpaddr);
    end
    // DONE back to IDLE
    @(posedge clk);
    #1;
  endtask

  // second i_valid during EXEC must be dropped
  task automatic check_ignored_valid();
    int dones;
    // add x3, x1, x2
    issue(32'h002081b3, '0, 64'd20, 64'd22);
    check_bit("o_busy", o_busy, 1'b1);
    i_inst     = 32'h402081b3;
    i_rs1_data = 64'd7;
    i_valid    = 1'b1;
    @(posedge clk);
    #1;
    i_valid = 1'b0;
    check_bit("o_done", o_done, 1'b1);
    dones = 0;
    repeat (5) begin
      if (o_done) dones++;
      @(posedge clk);
      #1;
    end
    retired += dones;
    check_count("o_done pulses", dones, 1);
    check_bit("o_rd_wen", o_rd_wen, 1'b1);
    check_data("o_rd_data", o_rd_data, 64'd42);
  endtask

  initial begin
    first_draw = $urandom(SEED);
    rst        = 1'b1;
    i_valid    = 1'b0;
    i_inst     = '0;
    i_pc       = '0;
    i_rs1_data = '0;
    i_rs2_data = '0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    // state right out of reset
    check_bit("o_busy", o_busy, 1'b0);
    check_bit("o_done", o_done, 1'b0);
    check_bit("o_rd_wen", o_rd_wen, 1'b0);
    check_bit("o_pc_jmp", o_pc_jmp, 1'b0);
    check_ignored_valid();
    for (int n = 0; n < NUM_ROWS; n++) begin
      run_row(ROWS[n]);
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+dv
rtl/exe_pkg.sv
rtl/csr_pkg.sv
rtl/exe_decode.sv
rtl/exe_alu.sv
rtl/exe_cycle_counter.sv
rtl/exe_csr_file.sv
rtl/exe_ctrl.sv
rtl/exe_top.sv
dv/exe_tb.sv

//--- Bender.yml
package:
  name: exe_stage

sources:
  - files:
      - rtl/exe_pkg.sv
      - rtl/csr_pkg.sv
      - rtl/exe_decode.sv
      - rtl/exe_alu.sv
      - rtl/exe_cycle_counter.sv
      - rtl/exe_csr_file.sv
      - rtl/exe_ctrl.sv
      - rtl/exe_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/exe_tb.sv
